// ==== source/rhythm_pkg.sv ====
package rhythm_pkg;

    //////////////////////////////
    // modes and levels
    //////////////////////////////

    localparam logic [1:0] MODE_GAME   = 2'd0;
    localparam logic [1:0] MODE_VOLUME = 2'd1;
    localparam logic [1:0] MODE_LEVEL  = 2'd2;

    // levels 0 to 2 end at the last beat, level 3 loops forever
    localparam logic [1:0] LEVEL_ENDLESS = 2'd3;

    // clock cycles per beat, indexed by level
    localparam logic [3:0][7:0] BEAT_CYCLES = {8'd4, 8'd4, 8'd6, 8'd8};

    //////////////////////////////
    // song length and lanes
    //////////////////////////////

    localparam int BEAT_W = 7;

    // last beat of the song
    localparam logic [BEAT_W-1:0] SONG_BEATS = 7'd96;

    // lane index 0..3 is F, G, H, J
    localparam int LANE_COUNT = 4;

    //////////////////////////////
    // song chart
    //////////////////////////////

    // one note code per two-beat slot, 0 is a rest
    localparam logic [2:0] CHART [48] = '{
        3'd1, 3'd1, 3'd5, 3'd5, 3'd6, 3'd6, 3'd5, 3'd0,
        3'd4, 3'd4, 3'd3, 3'd3, 3'd2, 3'd2, 3'd1, 3'd0,
        3'd5, 3'd5, 3'd4, 3'd4, 3'd3, 3'd3, 3'd2, 3'd0,
        3'd5, 3'd5, 3'd4, 3'd4, 3'd3, 3'd3, 3'd2, 3'd0,
        3'd1, 3'd1, 3'd5, 3'd5, 3'd6, 3'd6, 3'd5, 3'd0,
        3'd4, 3'd4, 3'd3, 3'd3, 3'd2, 3'd2, 3'd1, 3'd0
    };

endpackage

// ==== source/audio_pkg.sv ====
package audio_pkg;

    // note code width, 0 is a rest and 1..7 run C to B
    localparam int NOTE_W = 3;

    //////////////////////////////
    // tone dividers
    //////////////////////////////

    // half period in clock cycles, 100 MHz reference
    localparam logic [21:0] TONE_DIV [8] = '{
        22'd0,
        22'd190840,
        22'd170068,
        22'd151515,
        22'd143266,
        22'd127551,
        22'd113636,
        22'd101214
    };

    //////////////////////////////
    // volume
    //////////////////////////////

    localparam int VOL_W = 7;

    localparam logic [VOL_W-1:0] VOL_MAX   = 7'd99;
    localparam logic [VOL_W-1:0] VOL_RESET = 7'd50;

endpackage

// ==== source/mode_ctrl.sv ====
`timescale 1ns/1ps

module mode_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          mid_long,
    input  logic                          mid_press,
    input  logic                          up_press,
    input  logic                          down_press,
    input  logic                          running,
    input  logic [rhythm_pkg::BEAT_W-1:0] beat_cnt,
    output logic [1:0]                    mode,
    output logic [1:0]                    level,
    output logic [audio_pkg::VOL_W-1:0]   volume,
    output logic [15:0]                   light
);

    logic level_step;
    logic vol_mode;

    // level only changes at the start or the end of the song
    assign level_step = mid_press && !running && (mode == rhythm_pkg::MODE_LEVEL) &&
                        ((beat_cnt == '0) || (beat_cnt == rhythm_pkg::SONG_BEATS));
    assign vol_mode   = (mode == rhythm_pkg::MODE_VOLUME);

    //////////////////////////////
    // mode, level, volume
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode   <= rhythm_pkg::MODE_GAME;
            level  <= 2'd0;
            volume <= audio_pkg::VOL_RESET;
        end else begin
            // game -> volume -> level -> game
            if (mid_long && !running) begin
                case (mode)
                    rhythm_pkg::MODE_GAME:   mode <= rhythm_pkg::MODE_VOLUME;
                    rhythm_pkg::MODE_VOLUME: mode <= rhythm_pkg::MODE_LEVEL;
                    default:                 mode <= rhythm_pkg::MODE_GAME;
                endcase
            end
            // 3 wraps back to 0
            if (level_step) begin
                level <= level + 2'd1;
            end
            // saturating at both ends
            if (vol_mode && up_press && (volume < audio_pkg::VOL_MAX)) begin
                volume <= volume + 1'b1;
            end else if (vol_mode && down_press && (volume != '0)) begin
                volume <= volume - 1'b1;
            end
        end
    end

    //////////////////////////////
    // status leds
    //////////////////////////////

    always_comb begin
        light[15]    = (mode == rhythm_pkg::MODE_GAME);
        light[14]    = (mode == rhythm_pkg::MODE_VOLUME);
        light[13]    = (mode == rhythm_pkg::MODE_LEVEL);
        light[12]    = running;
        light[11:10] = level;
        // bar of tens, bit i lit once volume reaches 10*i
        for (int i = 1; i <= 9; i++) begin
            light[i] = (int'(volume) >= 10 * i);
        end
        light[0] = (volume != '0);
    end

endmodule

// ==== source/play_ctrl.sv ====
`timescale 1ns/1ps

module play_ctrl (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [1:0]                        mode,
    input  logic [1:0]                        level,
    input  logic                              mid_press,
    input  logic                              up_press,
    input  logic                              press_f,
    input  logic                              press_g,
    input  logic                              press_h,
    input  logic                              press_j,
    input  logic [rhythm_pkg::LANE_COUNT-1:0] wrong_lanes,
    output logic                              running,
    output logic                              ended,
    output logic                              restart,
    output logic                              win,
    output logic                              lose,
    output logic [rhythm_pkg::BEAT_W-1:0]     beat_cnt
);

    logic       game_mode;
    logic       any_key;
    logic       beat_en;
    logic       beat_tick;
    logic       endless;
    logic [7:0] cyc_cnt;

    assign game_mode = (mode == rhythm_pkg::MODE_GAME);
    assign any_key   = press_f | press_g | press_h | press_j;
    assign restart   = up_press & game_mode;
    assign lose      = |wrong_lanes;
    assign ended     = win | lose;
    assign endless   = (level == rhythm_pkg::LEVEL_ENDLESS);
    assign beat_en   = running & ~ended;
    assign beat_tick = beat_en && (cyc_cnt >= rhythm_pkg::BEAT_CYCLES[level] - 8'd1);

    //////////////////////////////
    // run / pause
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else if (restart || ended) begin
            running <= 1'b0;
        end else if (game_mode && mid_press) begin
            running <= ~running;
        end else if (game_mode && !running && any_key) begin
            // first key only starts play
            running <= 1'b1;
        end
    end

    //////////////////////////////
    // beat timer and counter
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc_cnt  <= 8'd0;
            beat_cnt <= '0;
            win      <= 1'b0;
        end else if (restart) begin
            cyc_cnt  <= 8'd0;
            beat_cnt <= '0;
            win      <= 1'b0;
        end else if (beat_tick) begin
            cyc_cnt <= 8'd0;
            if (endless) begin
                // wraps after beat 95
                if (beat_cnt >= rhythm_pkg::SONG_BEATS - 1'b1) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end else if (beat_cnt < rhythm_pkg::SONG_BEATS) begin
                beat_cnt <= beat_cnt + 1'b1;
                win      <= (beat_cnt == rhythm_pkg::SONG_BEATS - 1'b1) && !lose;
            end
        end else if (beat_en) begin
            cyc_cnt <= cyc_cnt + 8'd1;
        end
    end

endmodule

// ==== source/chart_rom.sv ====
`timescale 1ns/1ps

module chart_rom (
    input  logic [rhythm_pkg::BEAT_W-1:0] beat_cnt,
    input  logic                          running,
    output logic [1:0]                    lane_exp,
    output logic                          lane_valid,
    output logic [21:0]                   tone_div
);

    logic [rhythm_pkg::BEAT_W-2:0] slot;
    logic [audio_pkg::NOTE_W-1:0]  note;
    logic [audio_pkg::NOTE_W-1:0]  note_m1;

    // two beats per chart slot
    assign slot = beat_cnt[rhythm_pkg::BEAT_W-1:1];

    always_comb begin
        // beat 96 falls past the chart and reads as a rest
        if (int'(slot) < rhythm_pkg::SONG_BEATS / 2) begin
            note = rhythm_pkg::CHART[slot];
        end else begin
            note = '0;
        end
    end

    //////////////////////////////
    // lane and tone
    //////////////////////////////

    // C and G land on F, D and A on G, E and B on H, F on J
    assign note_m1    = note - 1'b1;
    assign lane_exp   = note_m1[1:0];

    // note is only due on the even beat of its slot
    assign lane_valid = !beat_cnt[0] && (note != '0);

    always_comb begin
        if (running && lane_valid) begin
            tone_div = audio_pkg::TONE_DIV[note];
        end else begin
            tone_div = 22'd0;
        end
    end

endmodule

// ==== source/lane_judge.sv ====
`timescale 1ns/1ps

module lane_judge (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              press_f,
    input  logic                              press_g,
    input  logic                              press_h,
    input  logic                              press_j,
    input  logic [1:0]                        lane_exp,
    input  logic                              lane_valid,
    input  logic                              running,
    input  logic                              restart,
    input  logic                              hack,
    output logic [rhythm_pkg::LANE_COUNT-1:0] wrong_lanes
);

    logic [rhythm_pkg::LANE_COUNT-1:0] presses;
    logic [rhythm_pkg::LANE_COUNT-1:0] wrong_hit;

    assign presses = {press_j, press_h, press_g, press_f};

    // a press is wrong off-beat or on the wrong lane
    always_comb begin
        for (int i = 0; i < rhythm_pkg::LANE_COUNT; i++) begin
            wrong_hit[i] = presses[i] && running && !hack &&
                           (!lane_valid || (lane_exp != 2'(i)));
        end
    end

    // sticky until the next restart
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wrong_lanes <= '0;
        end else if (restart) begin
            wrong_lanes <= '0;
        end else begin
            wrong_lanes <= wrong_lanes | wrong_hit;
        end
    end

endmodule

// ==== source/rhythm_game.sv ====
`timescale 1ns/1ps

module rhythm_game (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          up_press,
    input  logic                          mid_press,
    input  logic                          down_press,
    input  logic                          mid_long,
    input  logic                          press_f,
    input  logic                          press_g,
    input  logic                          press_h,
    input  logic                          press_j,
    input  logic                          hack,
    output logic [15:0]                   light,
    output logic [rhythm_pkg::BEAT_W-1:0] beat_cnt,
    output logic                          running,
    output logic                          win,
    output logic                          lose,
    output logic [audio_pkg::VOL_W-1:0]   volume,
    output logic [21:0]                   tone_div
);

    logic [1:0]                        mode;
    logic [1:0]                        level;
    logic                              restart;
    logic [1:0]                        lane_exp;
    logic                              lane_valid;
    logic [rhythm_pkg::LANE_COUNT-1:0] wrong_lanes;

    mode_ctrl i_mode_ctrl (
        .clk(clk), .arst_n(arst_n), .mid_long(mid_long), .mid_press(mid_press),
        .up_press(up_press), .down_press(down_press), .running(running),
        .beat_cnt(beat_cnt), .mode(mode), .level(level), .volume(volume), .light(light)
    );

    play_ctrl i_play_ctrl (
        .clk(clk), .arst_n(arst_n), .mode(mode), .level(level), .mid_press(mid_press),
        .up_press(up_press), .press_f(press_f), .press_g(press_g), .press_h(press_h),
        .press_j(press_j), .wrong_lanes(wrong_lanes), .running(running), .ended(),
        .restart(restart), .win(win), .lose(lose), .beat_cnt(beat_cnt)
    );

    chart_rom i_chart_rom (
        .beat_cnt(beat_cnt), .running(running), .lane_exp(lane_exp),
        .lane_valid(lane_valid), .tone_div(tone_div)
    );

    lane_judge i_lane_judge (
        .clk(clk), .arst_n(arst_n), .press_f(press_f), .press_g(press_g),
        .press_h(press_h), .press_j(press_j), .lane_exp(lane_exp), .lane_valid(lane_valid),
        .running(running), .restart(restart), .hack(hack), .wrong_lanes(wrong_lanes)
    );

endmodule

// ==== test/rhythm_game_assert.sv ====
`timescale 1ns/1ps

module rhythm_game_assert (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          running,
    input logic                          ended,
    input logic                          win,
    input logic                          lose,
    input logic [rhythm_pkg::BEAT_W-1:0] beat_cnt
);

    // count of failed properties
    int fail_count = 0;

    no_win_and_lose: assert property (@(posedge clk) disable iff (!arst_n) !(win && lose))
        else begin
            fail_count++;
            $error("win and lose are high together");
        end

    beat_in_song: assert property (@(posedge clk) disable iff (!arst_n)
        beat_cnt <= rhythm_pkg::SONG_BEATS)
        else begin
            fail_count++;
            $error("beat_cnt ran past the last beat");
        end

    // play stops one cycle after the game ends
    stop_after_end: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ended) |=> !running)
        else begin
            fail_count++;
            $error("running still high after the game ended");
        end

endmodule

bind play_ctrl rhythm_game_assert i_assert (
    .clk(clk), .arst_n(arst_n), .running(running), .ended(ended), .win(win),
    .lose(lose), .beat_cnt(beat_cnt)
);

// ==== test/rhythm_game_tb.sv ====
`timescale 1ns/1ps

module rhythm_game_tb;

    localparam int A_PULSE = 0;
    localparam int A_WAIT  = 1;
    localparam int A_IDLE  = 2;
    localparam int A_CHECK = 3;
    localparam int A_NEAR  = 4;
    localparam int A_TASK  = 5;
    localparam int A_END   = 6;

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // pulse bits are up, mid, down, long, then lanes F G H J
    // check codes 0 light, 1 level leds, 2 beat_cnt, 3 running, 4 win, 5 lose, 6 tone_div
    localparam int NROWS = 49;
    localparam int STEPS [NROWS][3] = '{
        '{A_CHECK, 0, 'h803F},
        '{A_CHECK, 2, 0},
        '{A_CHECK, 4, 0},
        '{A_CHECK, 5, 0},
        '{A_CHECK, 6, 0},
        '{A_END, 1, 0},
        '{A_TASK, 2, 0},
        '{A_END, 2, 0},
        // level mode, then tempo at level 2
        '{A_PULSE, 3, 1},
        '{A_PULSE, 1, 1},
        '{A_CHECK, 1, 1},
        '{A_PULSE, 1, 1},
        '{A_CHECK, 1, 2},
        '{A_PULSE, 3, 1},
        '{A_PULSE, 4, 1},
        '{A_IDLE, 40, 0},
        '{A_NEAR, 2, 10},
        '{A_PULSE, 1, 1},
        '{A_CHECK, 3, 0},
        '{A_IDLE, 20, 0},
        '{A_CHECK, 2, 10},
        '{A_END, 3, 0},
        // restart and go back to level 0
        '{A_PULSE, 0, 1},
        '{A_PULSE, 3, 2},
        '{A_PULSE, 1, 2},
        '{A_PULSE, 3, 1},
        '{A_CHECK, 1, 0},
        '{A_TASK, 4, 0},
        '{A_END, 4, 0},
        '{A_TASK, 5, 0},
        '{A_END, 5, 0},
        // full song at level 0
        '{A_PULSE, 0, 1},
        '{A_PULSE, 4, 1},
        '{A_WAIT, 96, 0},
        '{A_CHECK, 2, 96},
        '{A_CHECK, 4, 1},
        '{A_IDLE, 1, 0},
        '{A_CHECK, 3, 0},
        // endless level wraps
        '{A_PULSE, 3, 2},
        '{A_PULSE, 1, 3},
        '{A_PULSE, 3, 1},
        '{A_CHECK, 1, 3},
        '{A_PULSE, 0, 1},
        '{A_PULSE, 4, 1},
        '{A_WAIT, 96, 0},
        '{A_CHECK, 2, 0},
        '{A_CHECK, 4, 0},
        '{A_CHECK, 3, 1},
        '{A_END, 6, 0}
    };

    // first eight chart slots
    localparam int NOTES [8] = '{1, 1, 5, 5, 6, 6, 5, 0};

    logic                          clk;
    logic                          arst_n;
    logic [7:0]                    pulses;
    logic                          hack;
    logic [15:0]                   light;
    logic [rhythm_pkg::BEAT_W-1:0] beat_cnt;
    logic                          running;
    logic                          win;
    logic                          lose;
    logic [audio_pkg::VOL_W-1:0]   volume;
    logic [21:0]                   tone_div;
    logic [31:0]                   lfsr;
    int                            errors;

    rhythm_game i_rhythm_game (
        .clk(clk), .arst_n(arst_n), .up_press(pulses[0]), .mid_press(pulses[1]),
        .down_press(pulses[2]), .mid_long(pulses[3]), .press_f(pulses[4]),
        .press_g(pulses[5]), .press_h(pulses[6]), .press_j(pulses[7]), .hack(hack),
        .light(light), .beat_cnt(beat_cnt), .running(running), .win(win), .lose(lose),
        .volume(volume), .tone_div(tone_div)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // bit i lit when the tens digit reaches i and bit 0 for any volume
    function automatic logic [9:0] tens_bar(input int vol);
        logic [9:0] b;
        b[0] = (vol != 0);
        for (int i = 1; i <= 9; i++) begin
            b[i] = (vol / 10 >= i);
        end
        return b;
    endfunction

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR at %0t ns %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_sig(input int code, input int expected);
        case (code)
            0: check("light", expected, light);
            1: check("light[11:10]", expected, light[11:10]);
            2: check("beat_cnt", expected, beat_cnt);
            3: check("running", expected, running);
            4: check("win", expected, win);
            5: check("lose", expected, lose);
            default: check("tone_div", expected, tone_div);
        endcase
    endtask

    // one cycle high, then one cycle low
    task automatic pulse(input int sel, input int count);
        for (int n = 0; n < count; n++) begin
            pulses[sel] = 1'b1;
            step();
            pulses[sel] = 1'b0;
            step();
        end
    endtask

    task automatic wait_beats(input int beats);
        logic [rhythm_pkg::BEAT_W-1:0] last;
        int                            waited;
        for (int b = 0; b < beats; b++) begin
            last   = beat_cnt;
            waited = 0;
            while (beat_cnt == last && waited < 20) begin
                step();
                waited++;
            end
            if (beat_cnt == last) begin
                $display("beat_cnt stopped advancing at %0t ns", $time);
                errors++;
                return;
            end
        end
    endtask

    //////////////////////////////
    // tests that need a model
    //////////////////////////////

    task automatic volume_sweep();
        int vol;
        vol = 50;
        pulse(3, 1);
        check("light[15:13]", 3'b010, light[15:13]);
        for (int n = 0; n < 85; n++) begin
            if (n < 60) begin
                pulse(0, 1);
                vol = (vol < 99) ? vol + 1 : 99;
            end else begin
                pulse(2, 1);
                vol = (vol > 0) ? vol - 1 : 0;
            end
            check("volume", vol, volume);
            check("light[9:0]", tens_bar(vol), light[9:0]);
        end
    endtask

    task automatic correct_play();
        int waited;
        pulse(4, 1);
        for (int s = 0; s < 8; s++) begin
            waited = 0;
            while (beat_cnt != 2 * s && waited < 40) begin
                step();
                waited++;
            end
            if (beat_cnt != 2 * s) begin
                $display("beat %0d never came within 40 cycles", 2 * s);
                errors++;
                return;
            end
            check("tone_div", audio_pkg::TONE_DIV[NOTES[s]], tone_div);
            // lane is the note code less one wrapped over four lanes
            if (NOTES[s] != 0) begin
                pulse(4 + (NOTES[s] - 1) % 4, 1);
            end
        end
        check("lose", 0, lose);
        check("running", 1, running);
    endtask

    task automatic wrong_press();
        logic [1:0] lane;
        lane = 2'd0;
        // F is due on beat 0
        while (lane == 2'd0) begin
            lane[0] = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            lane[1] = lfsr[0];
            lfsr    = lfsr_step(lfsr);
        end
        pulse(0, 1);
        pulse(4, 1);
        pulse(4 + lane, 1);
        check("lose", 1, lose);
        check("running", 0, running);
        pulse(0, 1);
        check("lose", 0, lose);
        hack = 1'b1;
        pulse(4, 1);
        pulse(4 + lane, 1);
        check("lose", 0, lose);
        check("running", 1, running);
        hack = 1'b0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int test_start;
        int tests_run;
        int tests_failed;
        int near_exp;
        arst_n       = 1'b0;
        pulses       = '0;
        hack         = 1'b0;
        lfsr         = 32'h9e17_a766;
        errors       = 0;
        test_start   = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #10;
        arst_n = 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            case (STEPS[r][0])
                A_PULSE: pulse(STEPS[r][1], STEPS[r][2]);
                A_WAIT:  wait_beats(STEPS[r][1]);
                A_IDLE:  repeat (STEPS[r][1]) step();
                A_CHECK: check_sig(STEPS[r][1], STEPS[r][2]);
                A_NEAR: begin
                    // one beat either way is close enough
                    near_exp = STEPS[r][2];
                    if (int'(beat_cnt) + 1 < near_exp || int'(beat_cnt) > near_exp + 1) begin
                        check("beat_cnt", near_exp, beat_cnt);
                    end
                end
                A_TASK: begin
                    case (STEPS[r][1])
                        2: volume_sweep();
                        4: correct_play();
                        default: wrong_press();
                    endcase
                end
                default: begin
                    tests_run++;
                    if (errors != test_start) begin
                        tests_failed++;
                    end
                    $display("test %0d done with %0d errors", STEPS[r][1], errors - test_start);
                    test_start = errors;
                end
            endcase
        end
        errors = errors + i_rhythm_game.i_play_ctrl.i_assert.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rhythm_game.f ====
source/rhythm_pkg.sv
source/audio_pkg.sv
source/mode_ctrl.sv
source/play_ctrl.sv
source/chart_rom.sv
source/lane_judge.sv
source/rhythm_game.sv
test/rhythm_game_assert.sv
test/rhythm_game_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rhythm game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f rhythm_game.f --top-module rhythm_game_tb -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vrhythm_game_tb +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
